/* verilog.f */
source/fir_pkg.sv
source/tap_delay_line.sv
source/symmetric_preadder.sv
source/coeff_multiplier_bank.sv
source/adder_tree.sv
source/fir_filter.sv
tests/fir_checker.sv
tests/fir_props.sv
tests/fir_tb.sv

/* tests/fir_tb.sv */
/*
 * Testbench top for the FIR filter. Generates clock and reset, runs the
 * directed and seeded random tests and prints the summary.
 */

`timescale 1ns/10ps

module fir_tb;

	import fir_pkg::*;

	localparam int WAIT_LIMIT = 4 * FILTER_LATENCY;
	localparam int FULL_POS   = 2 ** (DATA_W - 1) - 1;

	logic  clk;
	logic  reset;
	logic  clk_ena;
	logic  in_valid;
	data_t in_data;
	logic  out_valid;
	data_t out_data;

	int checks;
	int checker_errors;
	int tb_errors;
	int tests_failed;
	int errors_at_start;
	int checks_at_start;

	fir_filter i_dut (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (clk_ena),
		.i_valid   (in_valid),
		.i_in      (in_data),
		.o_valid   (out_valid),
		.o_out     (out_data)
	);

	fir_checker u_checker (
		.clk         (clk),
		.reset       (reset),
		.i_clk_ena   (clk_ena),
		.i_valid     (in_valid),
		.i_in        (in_data),
		.i_valid_out (out_valid),
		.i_data_out  (out_data),
		.o_checks    (checks),
		.o_errors    (checker_errors)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic int error_total();
		return tb_errors + checker_errors;
	endfunction

	function automatic data_t random_sample();
		return data_t'($urandom);
	endfunction

	// samples within 256 of either rail
	function automatic data_t full_scale_sample();
		int margin;
		margin = $urandom % 256;
		if ($urandom % 2) begin
			return data_t'(FULL_POS - margin);
		end
		return data_t'(-FULL_POS - 1 + margin);
	endfunction

	// ********************
	// drive helpers
	// ********************

	task automatic drive(input logic ena, input logic vld, input data_t sample);
		@(negedge clk);
		clk_ena  = ena;
		in_valid = vld;
		in_data  = sample;
	endtask

	task automatic run_random(input int cycles, input int stall_pct, input int idle_pct,
			input bit near_full);
		logic  ena;
		logic  vld;
		data_t sample;
		for (int c = 0; c < cycles; c++) begin
			ena = ($urandom % 100) >= stall_pct;
			vld = ($urandom % 100) >= idle_pct;
			if (near_full) begin
				sample = full_scale_sample();
			end else begin
				sample = random_sample();
			end
			drive(ena, vld, sample);
		end
	endtask

	// feed idle cycles until o_valid has stayed low for a full latency
	task automatic drain();
		int quiet;
		int cycles;
		quiet  = 0;
		cycles = 0;
		while (quiet < FILTER_LATENCY && cycles < WAIT_LIMIT) begin
			drive(1'b1, 1'b0, '0);
			cycles++;
			if (out_valid) begin
				quiet = 0;
			end else begin
				quiet++;
			end
		end
		if (quiet < FILTER_LATENCY) begin
			$display("timed out waiting for o_valid to drain");
			tb_errors++;
		end
	endtask

	task automatic expect_cleared();
		if (out_valid !== 1'b0) begin
			$display("** Error o_valid: expected 0x0, got 0x%0h", out_valid);
			tb_errors++;
		end
		if (out_data !== '0) begin
			$display("** Error o_out: expected 0x00000, got 0x%05h", out_data);
			tb_errors++;
		end
	endtask

	// ********************
	// test bookkeeping
	// ********************

	task automatic begin_test();
		errors_at_start = error_total();
		checks_at_start = checks;
	endtask

	task automatic end_test(input string name);
		int errs;
		int n;
		// checker counters only change on falling edges
		@(posedge clk);
		n = checks - checks_at_start;
		if (n == 0) begin
			$display("%s: no output was checked", name);
			tb_errors++;
		end
		errs = error_total() - errors_at_start;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("test %s: %0d output checks, %0d errors", name, n, errs);
	endtask

	// ********************
	// tests
	// ********************

	task automatic test_reset();
		int  edges;
		logic seen;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		begin_test();
		repeat (5) begin
			drive(1'b1, 1'b0, '0);
			expect_cleared();
		end
		drive(1'b1, 1'b1, random_sample());
		edges = 0;
		seen  = 1'b0;
		while (!seen && edges < WAIT_LIMIT) begin
			drive(1'b1, 1'b0, '0);
			edges++;
			if (out_valid) begin
				seen = 1'b1;
			end else begin
				expect_cleared();
			end
		end
		if (!seen) begin
			$display("timed out waiting for o_valid after the first sample");
			tb_errors++;
		end else if (edges != FILTER_LATENCY) begin
			$display("** Error o_valid latency: expected 0x%0h, got 0x%0h",
				FILTER_LATENCY, edges);
			tb_errors++;
		end
		drain();
		end_test("reset");
	endtask

	task automatic test_impulse();
		int nonzero;
		begin_test();
		repeat (10) drive(1'b1, 1'b1, '0);
		drive(1'b1, 1'b1, data_t'(1000));
		nonzero = 0;
		repeat (NUM_TAPS + FILTER_LATENCY + 5) begin
			drive(1'b1, 1'b1, '0);
			if (out_valid && out_data != '0) begin
				nonzero++;
			end
		end
		if (nonzero == 0) begin
			$display("impulse response never appeared on o_out");
			tb_errors++;
		end
		drain();
		end_test("impulse");
	endtask

	task automatic test_random(input string name, input int cycles, input int stall_pct,
			input int idle_pct, input bit near_full);
		begin_test();
		run_random(cycles, stall_pct, idle_pct, near_full);
		drain();
		end_test(name);
	endtask

	initial begin
		void'($urandom(32'h3e1b));
		reset        = 1'b1;
		clk_ena      = 1'b0;
		in_valid     = 1'b0;
		in_data      = '0;
		tb_errors    = 0;
		tests_failed = 0;

		test_reset();
		test_impulse();
		test_random("continuous", 300, 0, 0, 1'b0);
		test_random("stalls", 300, 30, 0, 1'b0);
		test_random("sparse_valid", 300, 0, 50, 1'b0);
		test_random("wrap_around", 200, 0, 0, 1'b1);

		$display("summary: 6 tests, %0d failed, %0d output checks, %0d errors",
			tests_failed, checks, error_total());
		if (error_total() == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* tests/fir_props.sv */
/*
 * Concurrent assertions on the FIR filter top level, bound into every
 * fir_filter instance. Covers reset clearing and holding during stalls.
 */

`timescale 1ns/10ps

module fir_props (
	input logic           clk,
	input logic           reset,
	input logic           i_clk_ena,
	input logic           i_valid_out,
	input fir_pkg::data_t i_data_out
);

	import fir_pkg::*;

	// outputs are cleared while reset is high
	reset_clears: assert property (@(posedge clk)
		reset |=> (!i_valid_out && i_data_out == '0))
		else $error("outputs not cleared during reset");

	// a disabled edge leaves both outputs untouched
	hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		!i_clk_ena |=> ($stable(i_data_out) && $stable(i_valid_out)))
		else $error("outputs changed on a disabled clock edge");

endmodule

bind fir_filter fir_props u_props (
	.clk         (clk),
	.reset       (reset),
	.i_clk_ena   (i_clk_ena),
	.i_valid_out (o_valid),
	.i_data_out  (o_out)
);

/* tests/fir_checker.sv */
/*
 * Reference model and scoreboard for the FIR filter testbench. Tracks the
 * input history on enabled edges and compares o_valid and o_out with it.
 */

`timescale 1ns/10ps

module fir_checker (
	input  logic           clk,
	input  logic           reset,
	input  logic           i_clk_ena,
	input  logic           i_valid,
	input  fir_pkg::data_t i_in,
	input  logic           i_valid_out,
	input  fir_pkg::data_t i_data_out,
	output int             o_checks,
	output int             o_errors
);

	import fir_pkg::*;

	// center tap index, pairs are 0 .. HALF-1
	localparam int HALF = NUM_TAPS / 2;
	localparam int LAST = FILTER_LATENCY - 1;

	longint history   [NUM_TAPS];
	longint exp_data  [FILTER_LATENCY];
	logic   exp_valid [FILTER_LATENCY];

	// two's complement wrap to DATA_W bits, read back as signed
	function automatic longint wrap_data(input longint v);
		longint m;
		m = v & ((longint'(1) << DATA_W) - 1);
		if (m >= (longint'(1) << (DATA_W - 1))) begin
			m = m - (longint'(1) << DATA_W);
		end
		return m;
	endfunction

	// filter response for the current history
	function automatic longint filter_output();
		longint acc;
		longint pair;
		longint prod;
		acc = 0;
		for (int k = 0; k <= HALF; k++) begin
			if (k < HALF) begin
				pair = wrap_data(history[k] + history[NUM_TAPS-1-k]);
			end else begin
				pair = history[HALF];
			end
			prod = pair * longint'(COEFF[k]);
			acc  = acc + wrap_data(prod >>> SCALE_SHIFT);
		end
		return wrap_data(acc);
	endfunction

	task automatic clear_model();
		foreach (history[k]) history[k] = 0;
		foreach (exp_data[k]) begin
			exp_data[k]  = 0;
			exp_valid[k] = 1'b0;
		end
	endtask

	initial begin
		o_checks = 0;
		o_errors = 0;
		clear_model();
	end

	// ********************
	// model update
	// ********************

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			clear_model();
		end else if (i_clk_ena) begin
			for (int k = NUM_TAPS - 1; k > 0; k--) begin
				history[k] = history[k-1];
			end
			history[0] = longint'(i_in);
			for (int k = LAST; k > 0; k--) begin
				exp_data[k]  = exp_data[k-1];
				exp_valid[k] = exp_valid[k-1];
			end
			exp_data[0]  = filter_output();
			exp_valid[0] = i_valid;
		end
	end

	// ********************
	// compare
	// ********************

	// outputs only move on rising edges, so the falling edge sees them settled
	always @(negedge clk) begin
		if (!reset) begin
			if (i_valid_out !== exp_valid[LAST]) begin
				$display("** Error o_valid: expected 0x%0h, got 0x%0h at %0t",
					exp_valid[LAST], i_valid_out, $time);
				o_errors++;
			end
			if (i_valid_out === 1'b1) begin
				o_checks++;
				if (i_data_out !== data_t'(exp_data[LAST])) begin
					$display("** Error o_out: expected 0x%05h, got 0x%05h at %0t",
						data_t'(exp_data[LAST]), i_data_out, $time);
					o_errors++;
				end
			end
		end
	end

endmodule

/* source/fir_filter.sv */
/*
 * Top level of the 45-tap symmetric FIR filter. Chains the tap line,
 * pre-adder, multiplier bank and adder tree, and delays i_valid so that
 * o_valid marks the output computed from the matching input sample.
 */

`timescale 1ns/10ps

module fir_filter (
	input  logic           clk,
	input  logic           reset,
	input  logic           i_clk_ena,
	input  logic           i_valid,
	input  fir_pkg::data_t i_in,
	output logic           o_valid,
	output fir_pkg::data_t o_out
);

	import fir_pkg::*;

	data_t taps      [NUM_TAPS];
	data_t pair_sums [NUM_UNIQ];
	data_t products  [NUM_UNIQ];

	logic [FILTER_LATENCY-1:0] valid_pipe;

	// ********************
	// data path
	// ********************

	tap_delay_line u_taps (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_in      (i_in),
		.o_taps    (taps)
	);

	symmetric_preadder u_preadd (
		.clk         (clk),
		.reset       (reset),
		.i_clk_ena   (i_clk_ena),
		.i_taps      (taps),
		.o_pair_sums (pair_sums)
	);

	coeff_multiplier_bank u_mult (
		.clk         (clk),
		.reset       (reset),
		.i_clk_ena   (i_clk_ena),
		.i_pair_sums (pair_sums),
		.o_products  (products)
	);

	adder_tree u_tree (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_products (products),
		.o_sum      (o_out)
	);

	// ********************
	// valid delay
	// ********************

	// one bit per pipeline register on the data path
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_pipe <= '0;
		end else if (i_clk_ena) begin
			valid_pipe <= {valid_pipe[FILTER_LATENCY-2:0], i_valid};
		end
	end

	assign o_valid = valid_pipe[FILTER_LATENCY-1];

endmodule

/* source/adder_tree.sv */
/*
 * Registered binary adder tree of the FIR filter. Reduces the normalized
 * products pairwise, one register level per step, to a single sum.
 * Odd leftovers go through a bypass register so all paths stay equal.
 */

`timescale 1ns/10ps

module adder_tree (
	input  logic           clk,
	input  logic           reset,
	input  logic           i_clk_ena,
	input  fir_pkg::data_t i_products [fir_pkg::NUM_UNIQ],
	output fir_pkg::data_t o_sum
);

	import fir_pkg::*;

	// number of values entering level lvl, level 0 being the products
	function automatic int level_count(input int lvl);
		int n;
		n = NUM_UNIQ;
		for (int i = 0; i < lvl; i++) begin
			n = (n + 1) / 2;
		end
		return n;
	endfunction

	// row l holds the registered outputs of tree level l
	// only the first level_count(l+1) entries of a row are live
	data_t tree [TREE_LEVELS][NUM_UNIQ];

	// ********************
	// tree levels
	// ********************

	for (genvar l = 0; l < TREE_LEVELS; l++) begin : g_level
		localparam int N_IN = level_count(l);

		data_t src [NUM_UNIQ];

		// first level reads the products, later ones the row below
		if (l == 0) begin : g_first
			assign src = i_products;
		end else begin : g_next
			assign src = tree[l-1];
		end

		always_ff @(posedge clk or posedge reset) begin
			if (reset) begin
				tree[l] <= '{default: '0};
			end else if (i_clk_ena) begin
				// wrapping adds, the order of reduction does not matter
				for (int j = 0; j < N_IN / 2; j++) begin
					tree[l][j] <= src[2*j] + src[2*j+1];
				end
				// bypass register for an odd leftover
				if (N_IN % 2 == 1) begin
					tree[l][N_IN/2] <= src[N_IN-1];
				end
			end
		end
	end

	// ********************
	// result
	// ********************

	// the last level has exactly one live entry
	assign o_sum = tree[TREE_LEVELS-1][0];

endmodule

/* source/coeff_multiplier_bank.sv */
/*
 * Multiplier stage of the FIR filter. Each pair sum is multiplied by its
 * constant coefficient, the full product is normalized by an arithmetic
 * shift and the low bits are registered for the adder tree.
 */

`timescale 1ns/10ps

module coeff_multiplier_bank (
	input  logic           clk,
	input  logic           reset,
	input  logic           i_clk_ena,
	input  fir_pkg::data_t i_pair_sums [fir_pkg::NUM_UNIQ],
	output fir_pkg::data_t o_products [fir_pkg::NUM_UNIQ]
);

	import fir_pkg::*;

	logic signed [PROD_W-1:0] full_prod [NUM_UNIQ];
	logic signed [PROD_W-1:0] scaled    [NUM_UNIQ];

	// ********************
	// multiply and normalize
	// ********************

	// both operands signed, so the product is sign-extended to PROD_W
	always_comb begin
		for (int k = 0; k < NUM_UNIQ; k++) begin
			full_prod[k] = i_pair_sums[k] * COEFF[k];
			scaled[k]    = full_prod[k] >>> SCALE_SHIFT;
		end
	end

	// ********************
	// product registers
	// ********************

	// keep only the low DATA_W bits of the shifted product
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_products <= '{default: '0};
		end else if (i_clk_ena) begin
			for (int k = 0; k < NUM_UNIQ; k++) begin
				o_products[k] <= scaled[k][DATA_W-1:0];
			end
		end
	end

endmodule

/* source/symmetric_preadder.sv */
/*
 * Pre-adder stage of the symmetric FIR filter. Adds each pair of
 * mirrored taps so that one multiplier serves two taps, and registers
 * the center tap alone to keep it aligned with the pairs.
 */

`timescale 1ns/10ps

module symmetric_preadder (
	input  logic           clk,
	input  logic           reset,
	input  logic           i_clk_ena,
	input  fir_pkg::data_t i_taps [fir_pkg::NUM_TAPS],
	output fir_pkg::data_t o_pair_sums [fir_pkg::NUM_UNIQ]
);

	import fir_pkg::*;

	// odd center tap index, which is also the last pair-sum slot
	localparam int CENTER = NUM_UNIQ - 1;

	// ********************
	// pair sums
	// ********************

	// sums wrap at DATA_W bits
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_pair_sums <= '{default: '0};
		end else if (i_clk_ena) begin
			for (int k = 0; k < CENTER; k++) begin
				o_pair_sums[k] <= i_taps[k] + i_taps[NUM_TAPS-1-k];
			end
			// center tap has no partner
			o_pair_sums[CENTER] <= i_taps[CENTER];
		end
	end

endmodule

/* source/tap_delay_line.sv */
/*
 * Input sample delay line of the FIR filter. A new sample enters tap 0
 * on every enabled edge and the older ones move one tap further.
 */

`timescale 1ns/10ps

module tap_delay_line (
	input  logic           clk,
	input  logic           reset,
	input  logic           i_clk_ena,
	input  fir_pkg::data_t i_in,
	output fir_pkg::data_t o_taps [fir_pkg::NUM_TAPS]
);

	import fir_pkg::*;

	// ********************
	// shift register
	// ********************

	// tap 0 holds the newest sample, tap NUM_TAPS-1 the oldest
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_taps <= '{default: '0};
		end else if (i_clk_ena) begin
			o_taps[0] <= i_in;
			for (int k = 1; k < NUM_TAPS; k++) begin
				o_taps[k] <= o_taps[k-1];
			end
		end
	end

	// whole line holds while the clock enable is low

endmodule

/* source/fir_pkg.sv */
/*
 * Shared widths, tap counts, pipeline latency and the coefficient table
 * of the 45-tap symmetric FIR filter. Every RTL stage imports it.
 */

package fir_pkg;

	// ********************
	// data path widths
	// ********************

	// samples, pair sums, normalized products and tree sums
	localparam int DATA_W = 18;

	typedef logic signed [DATA_W-1:0] data_t;

	// full signed product before normalization
	localparam int PROD_W = 2 * DATA_W;

	// products are shifted right arithmetically, low DATA_W bits kept
	localparam int SCALE_SHIFT = 17;

	// ********************
	// filter geometry
	// ********************

	localparam int NUM_TAPS = 45;

	// mirrored pairs 0..21 and the center tap at 22
	localparam int NUM_UNIQ = (NUM_TAPS + 1) / 2;

	// 23 -> 12 -> 6 -> 3 -> 2 -> 1
	localparam int TREE_LEVELS = 5;

	// tap line + pre-adder + multiplier + one edge per tree level
	localparam int FILTER_LATENCY = 3 + TREE_LEVELS;

	// ********************
	// coefficients
	// ********************

	// lowpass response, entry k applies to taps k and NUM_TAPS-1-k
	// entry NUM_UNIQ-1 is the center tap alone
	localparam data_t COEFF [NUM_UNIQ] = '{
		88,
		0,
		-97,
		-197,
		-294,
		-380,
		-447,
		-490,
		-504,
		-481,
		-420,
		-319,
		-178,
		0,
		212,
		451,
		710,
		980,
		1252,
		1514,
		1756,
		1971,
		2147
	};

endpackage
